// ==== sim.f ====
muldiv_pkg.sv
mul_unit.sv
div_unit.sv
hilo_regs.sv
muldiv_unit.sv
tb_clk_gen.sv
tb_muldiv.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the muldiv testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_muldiv -f sim.f -o tb_muldiv

./obj_dir/tb_muldiv > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

echo "simulation passed"

// ==== tb_muldiv.sv ====
`timescale 1ns/1ps

module tb_muldiv import muldiv_pkg::*; ();

    localparam int SEED        = 26738;
    localparam int N_DIRECTED  = 16;
    localparam int N_RANDOM    = 400;
    localparam int N_OPS       = N_DIRECTED + N_RANDOM;
    localparam int CYCLE_LIMIT = 40 * N_OPS + 200;   // reset and slack on top

    logic       clk;
    logic       rst_n;
    muldiv_op_t op;
    word_t      in0;
    word_t      in1;
    word_t      hi;
    word_t      lo;
    logic       ready;

    // reference hi/lo
    word_t exp_hi;
    word_t exp_lo;

    int error_cnt = 0;
    int check_cnt = 0;
    int cycle_cnt = 0;

    tb_clk_gen #(
        .PERIOD_NS  (100),
        .RST_CYCLES (8)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    muldiv_unit #(
        .MUL_STAGES (2)
    ) u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (op),
        .in0   (in0),
        .in1   (in1),
        .hi    (hi),
        .lo    (lo),
        .ready (ready)
    );

    task automatic check_word(input string what, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_ready(input string what, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("error at %0t ns: ready %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // extreme values show up often
    function automatic word_t rand_word();
        int unsigned sel;
        sel = $urandom() % 8;
        case (sel)
            0: return 32'h0000_0000;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            3: return 32'h7fff_ffff;
            4: return word_t'($urandom() % 16);   // small values
            default: return word_t'($urandom());
        endcase
    endfunction

    function automatic muldiv_op_t rand_op();
        int unsigned sel;
        sel = $urandom() % 6;
        case (sel)
            0: return op_mult;
            1: return op_multu;
            2: return op_div;
            3: return op_divu;
            4: return op_mthi;
            default: return op_mtlo;
        endcase
    endfunction

    // any code including op_none for the back-pressure cycle
    function automatic muldiv_op_t rand_any_op();
        logic [2:0] code;
        code = 3'($urandom() % 7);
        return muldiv_op_t'(code);
    endfunction

    // 64-bit product from sign- or zero-extended operands
    function automatic dword_t model_product(input muldiv_op_t o, input word_t a, input word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        dword_t             ua;
        dword_t             ub;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        if (o == op_mult) begin
            return dword_t'(sa * sb);
        end
        return ua * ub;
    endfunction

    // returns {remainder, quotient} in hi:lo layout
    function automatic dword_t model_divide(input muldiv_op_t o, input word_t a, input word_t b);
        int sa;
        int sb;
        sa = $signed(a);
        sb = $signed(b);
        if (b == 32'h0) begin
            return {a, 32'hffff_ffff};   // divide by zero rule
        end
        if (o == op_div && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return {32'h0, a};
        end
        if (o == op_div) begin
            return {word_t'(sa % sb), word_t'(sa / sb)};   // truncates toward zero
        end
        return {a % b, a / b};
    endfunction

    task automatic apply_model(input muldiv_op_t o, input word_t a, input word_t b);
        dword_t res;
        case (o)
            op_mult, op_multu: begin
                res    = model_product(o, a, b);
                exp_hi = res[63:32];
                exp_lo = res[31:0];
            end
            op_div, op_divu: begin
                res    = model_divide(o, a, b);
                exp_hi = res[63:32];
                exp_lo = res[31:0];
            end
            op_mthi: exp_hi = a;
            op_mtlo: exp_lo = a;
            default: ;
        endcase
    endtask

    // returns at a falling edge with ready high
    task automatic wait_ready();
        @(negedge clk);
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic issue_op(input muldiv_op_t o, input word_t a, input word_t b);
        dword_t prev;
        logic   long_op;
        long_op = (o == op_mult || o == op_multu || o == op_div || o == op_divu);
        wait_ready();
        @(posedge clk);
        op  <= o;
        in0 <= a;
        in1 <= b;
        @(posedge clk);   // accepted here
        if (long_op) begin
            // seen at the next edge with ready low and must be dropped
            op  <= rand_any_op();
            in0 <= rand_word();
            in1 <= rand_word();
        end else begin
            op <= op_none;
        end
        prev = {exp_hi, exp_lo};
        apply_model(o, a, b);
        @(negedge clk);
        if (long_op) begin
            check_ready($sformatf("after %s accept", o.name()), ready, 1'b0);
            // hi/lo hold their old values for the whole busy time
            while (ready !== 1'b1) begin
                check_word($sformatf("%s hi while busy", o.name()), hi, prev[63:32]);
                check_word($sformatf("%s lo while busy", o.name()), lo, prev[31:0]);
                @(posedge clk);
                op <= op_none;
                @(negedge clk);
            end
        end else begin
            check_ready($sformatf("after %s", o.name()), ready, 1'b1);
        end
        check_word($sformatf("%s hi", o.name()), hi, exp_hi);
        check_word($sformatf("%s lo", o.name()), lo, exp_lo);
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles, the unit never became ready again",
                     cycle_cnt);
            $display("checks: %0d  errors: %0d", check_cnt, error_cnt);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        muldiv_op_t  o;
        word_t       a;
        word_t       b;

        op     <= op_none;
        in0    <= '0;
        in1    <= '0;
        exp_hi = '0;
        exp_lo = '0;
        void'($urandom(SEED));

        // inside reset
        @(negedge clk);
        @(negedge clk);
        check_ready("in reset", ready, 1'b0);
        check_word("hi in reset", hi, 32'h0);
        check_word("lo in reset", lo, 32'h0);

        wait (rst_n === 1'b1);
        wait_ready();
        check_word("hi after reset", hi, 32'h0);
        check_word("lo after reset", lo, 32'h0);

        // directed corners
        issue_op(op_mult,  32'h8000_0000, 32'h8000_0000);
        issue_op(op_mult,  32'h7fff_ffff, 32'h8000_0000);
        issue_op(op_multu, 32'hffff_ffff, 32'hffff_ffff);
        issue_op(op_mult,  32'hffff_ffff, 32'h0000_0001);
        issue_op(op_div,   32'h8000_0000, 32'hffff_ffff);   // overflow case
        issue_op(op_div,   32'hffff_fff9, 32'h0000_0002);   // -7 / 2
        issue_op(op_div,   32'h0000_0007, 32'hffff_fffe);   // 7 / -2
        issue_op(op_div,   32'hffff_fff9, 32'hffff_fffe);   // -7 / -2
        issue_op(op_div,   32'h0000_3039, 32'h0000_0000);
        issue_op(op_div,   32'h8000_0000, 32'h0000_0000);
        issue_op(op_divu,  32'hffff_ffff, 32'h0000_0000);
        issue_op(op_divu,  32'h8000_0000, 32'hffff_ffff);
        issue_op(op_mthi,  32'hdead_beef, 32'h0000_0000);
        issue_op(op_mtlo,  32'h0123_4567, 32'hffff_ffff);
        issue_op(op_divu,  32'h0000_0064, 32'h0000_0007);
        issue_op(op_mult,  32'h0000_0000, word_t'($urandom()));

        for (int i = 0; i < N_RANDOM; i++) begin
            o = rand_op();
            a = rand_word();
            b = rand_word();
            issue_op(o, a, b);
        end

        repeat (2) @(posedge clk);
        $display("checks: %0d  errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    // free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // reset low for the first RST_CYCLES rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;   // released on a rising edge
    end

endmodule

// ==== muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit import muldiv_pkg::*; #(
    parameter int MUL_STAGES = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  muldiv_op_t op,
    input  word_t      in0,
    input  word_t      in1,
    output word_t      hi,
    output word_t      lo,
    output logic       ready
);

    logic accept;
    logic mul_start;
    logic mul_signed;
    logic div_start;
    logic div_signed;

    dword_t mul_product;
    logic   mul_done;
    word_t  div_quo;
    word_t  div_rem;
    logic   div_done;

    logic busy;
    logic busy_d;

    hilo_wr_t wr;

    // issue decode, ops ignored while ready is low
    always_comb begin
        accept     = ready && (op != op_none);
        mul_start  = accept && (op == op_mult || op == op_multu);
        mul_signed = (op == op_mult);
        div_start  = accept && (op == op_div || op == op_divu);
        div_signed = (op == op_div);
    end

    // busy from start until the matching done
    always_comb begin
        busy_d = busy;
        if (mul_start || div_start) begin
            busy_d = 1'b1;
        end else if (mul_done || div_done) begin
            busy_d = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            ready <= 1'b0;   // low during reset
        end else begin
            busy  <= busy_d;
            ready <= !busy_d;
        end
    end

    // write-back select, only one source can finish per cycle
    always_comb begin
        wr = '0;
        if (mul_done) begin
            wr.wr_hi = 1'b1;
            wr.wr_lo = 1'b1;
            wr.hi    = mul_product[63:32];
            wr.lo    = mul_product[31:0];
        end else if (div_done) begin
            wr.wr_hi = 1'b1;
            wr.wr_lo = 1'b1;
            wr.hi    = div_rem;   // remainder to hi
            wr.lo    = div_quo;
        end else if (accept && op == op_mthi) begin
            wr.wr_hi = 1'b1;
            wr.hi    = in0;
        end else if (accept && op == op_mtlo) begin
            wr.wr_lo = 1'b1;
            wr.lo    = in0;
        end
    end

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (mul_start),
        .is_signed (mul_signed),
        .a         (in0),
        .b         (in1),
        .product   (mul_product),
        .done      (mul_done)
    );

    div_unit u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (in0),
        .divisor   (in1),
        .quotient  (div_quo),
        .remainder (div_rem),
        .done      (div_done)
    );

    hilo_regs u_hilo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .hi    (hi),
        .lo    (lo)
    );

endmodule

// ==== hilo_regs.sv ====
`timescale 1ns/1ps

module hilo_regs import muldiv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  hilo_wr_t wr,
    output word_t    hi,
    output word_t    lo
);

    word_t hi_q;
    word_t lo_q;

    // hi and lo have their own enables
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (wr.wr_hi) begin
                hi_q <= wr.hi;
            end
            if (wr.wr_lo) begin
                lo_q <= wr.lo;
            end
        end
    end

    // always visible, mfhi/mflo read these directly
    assign hi = hi_q;
    assign lo = lo_q;

endmodule

// ==== div_unit.sv ====
`timescale 1ns/1ps

module div_unit import muldiv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  is_signed,
    input  word_t dividend,
    input  word_t divisor,
    output word_t quotient,
    output word_t remainder,
    output logic  done
);

    div_state_t state;
    logic [4:0] cnt;          // step counter, 32 steps

    word_t rem_q;             // partial remainder
    word_t quo_q;             // dividend shifts out, quotient shifts in
    word_t dvs_q;             // divisor magnitude
    word_t dend_q;            // original dividend, for div by zero
    logic  neg_quo;
    logic  neg_rem;
    logic  dvz;

    word_t       dend_mag;
    word_t       dvs_mag;
    logic [32:0] shifted;
    logic [33:0] diff;

    // operand magnitudes at start
    always_comb begin
        dend_mag = (is_signed && dividend[31]) ? -dividend : dividend;
        dvs_mag  = (is_signed && divisor[31])  ? -divisor  : divisor;
    end

    // one restoring step
    always_comb begin
        shifted = {rem_q, quo_q[31]};
        diff    = {1'b0, shifted} - {2'b00, dvs_q};
    end

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                        cnt   <= '0;
                    end
                end
                run: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd31) begin
                        state <= finish;
                    end
                end
                finish: begin
                    state <= idle;
                    done  <= 1'b1;   // results valid next cycle
                end
                default: state <= idle;
            endcase
        end
    end

    // datapath, payload only
    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    rem_q   <= '0;
                    quo_q   <= dend_mag;
                    dvs_q   <= dvs_mag;
                    dend_q  <= dividend;
                    neg_quo <= is_signed && (dividend[31] ^ divisor[31]);
                    neg_rem <= is_signed && dividend[31];   // follows the dividend
                    dvz     <= (divisor == '0);
                end
            end
            run: begin
                if (!diff[33]) begin
                    rem_q <= diff[31:0];
                    quo_q <= {quo_q[30:0], 1'b1};
                end else begin
                    rem_q <= shifted[31:0];   // restore
                    quo_q <= {quo_q[30:0], 1'b0};
                end
            end
            finish: begin
                if (dvz) begin
                    quotient  <= '1;
                    remainder <= dend_q;
                end else begin
                    // most negative / -1 wraps back to itself here
                    quotient  <= neg_quo ? -quo_q : quo_q;
                    remainder <= neg_rem ? -rem_q : rem_q;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit import muldiv_pkg::*; #(
    parameter int MUL_STAGES = 2
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  logic   is_signed,
    input  word_t  a,
    input  word_t  b,
    output dword_t product,
    output logic   done
);

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] full_prod;

    dword_t                prod_q [MUL_STAGES];
    logic [MUL_STAGES-1:0] vld_q;

    // one extra bit so signed and unsigned share the same multiplier
    always_comb begin
        a_ext     = {is_signed & a[31], a};
        b_ext     = {is_signed & b[31], b};
        full_prod = a_ext * b_ext;
    end

    // product pipeline, no reset on payload
    always_ff @(posedge clk) begin
        prod_q[0] <= full_prod[63:0];
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    // valid bit follows the data down the pipe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start;
            for (int i = 1; i < MUL_STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    assign product = prod_q[MUL_STAGES-1];
    assign done    = vld_q[MUL_STAGES-1];   // last stage valid

endmodule

// ==== muldiv_pkg.sv ====
package muldiv_pkg;

    // operand and hi/lo register width
    typedef logic [31:0] word_t;

    // full product, hi half in [63:32]
    typedef logic [63:0] dword_t;

    // issue operations
    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_mult  = 3'd1,   // signed multiply
        op_multu = 3'd2,   // unsigned multiply
        op_div   = 3'd3,   // signed divide
        op_divu  = 3'd4,   // unsigned divide
        op_mthi  = 3'd5,   // in0 -> hi
        op_mtlo  = 3'd6    // in0 -> lo
    } muldiv_op_t;

    // divider control FSM
    typedef enum logic [1:0] {
        idle   = 2'd0,
        run    = 2'd1,   // shift-subtract steps
        finish = 2'd2    // sign fix-up and done
    } div_state_t;

    // one write-back to the hi/lo pair
    typedef struct packed {
        logic  wr_hi;
        logic  wr_lo;
        word_t hi;
        word_t lo;
    } hilo_wr_t;

endpackage
